/* flist.f */
+incdir+source
+incdir+test
source/isa_pkg.sv
source/cap_pkg.sv
source/opcode_decoder.sv
source/fetch_bounds_check.sv
source/branch_target_calc.sv
source/dec_output_reg.sv
source/ir_decoder_top.sv
test/tb_ir_decoder.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module tb_ir_decoder -o sim_tb
out="$(./obj_dir/sim_tb)"
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
else
  exit 1
fi

/* test/tb_vectors.svh */
// stimulus and expected values for tb_ir_decoder, included inside the module
// bounds rows get random pc and base from the seeded generator
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic load_vectors();
  row_t             r;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] p;
  // class, enables and indices
  r = dec_row("jal", 32'h008000ef, 0, PL_JAL, 0, 0, 1, 4'b0010, SYS_NONE, CAP_NONE, 0);
  r.chk_tgt = 1;
  r.exp_btarget = 32'h0000_1008;
  rows.push_back(r);
  rows.push_back(dec_row("jalr", 32'h000100e7, 0, PL_JALR, 2, 0, 1, 4'b1010, SYS_NONE,
                         CAP_NONE, 0));
  r = dec_row("beq", 32'h00208863, 0, PL_BRANCH, 1, 2, 0, 4'b1100, SYS_NONE, CAP_NONE, 0);
  r.chk_tgt = 1;
  r.exp_btarget = 32'h0000_1010;
  rows.push_back(r);
  r.name = "beq_comp";
  r.pc = 32'h0000_2000;
  r.comp = 1;
  r.exp_btarget = 32'h0000_2010;
  r.exp_pc_nxt = 32'h0000_2002;   // compressed step
  rows.push_back(r);
  rows.push_back(dec_row("lw", 32'h0000a183, 0, PL_LS, 1, 0, 3, 4'b1010, SYS_NONE, CAP_NONE, 0));
  rows.push_back(dec_row("sw", 32'h0020a023, 0, PL_LS, 1, 2, 0, 4'b1100, SYS_NONE, CAP_NONE, 0));
  rows.push_back(dec_row("lui", 32'h123452b7, 0, PL_ALU, 0, 0, 5, 4'b0010, SYS_NONE, CAP_NONE, 0));
  rows.push_back(dec_row("add", 32'h002081b3, 0, PL_ALU, 1, 2, 3, 4'b1110, SYS_NONE, CAP_NONE, 0));
  rows.push_back(dec_row("mul", 32'h022081b3, 0, PL_MULT, 1, 2, 3, 4'b1110, SYS_NONE,
                         CAP_NONE, 0));
  // illegal encodings
  rows.push_back(dec_row("jalr_f3", 32'h000110e7, 0, PL_JALR, 2, 0, 1, 4'b1010, SYS_NONE,
                         CAP_NONE, 1));
  rows.push_back(dec_row("slli_bad", 32'h40109093, 0, PL_ALU, 1, 0, 1, 4'b1010, SYS_NONE,
                         CAP_NONE, 1));
  rows.push_back(dec_row("andn", 32'h4020f1b3, 0, PL_ALU, 1, 2, 3, 4'b1110, SYS_NONE,
                         CAP_NONE, 1));
  rows.push_back(dec_row("ecall_rd", 32'h000000f3, 0, PL_BRANCH, 0, 0, 0, 4'b0000, SYS_ECALL,
                         CAP_NONE, 1));
  rows.push_back(dec_row("bad_op", 32'h0000007f, 0, PL_ALU, 0, 0, 0, 4'b0000, SYS_NONE,
                         CAP_NONE, 1));
  // system control
  rows.push_back(dec_row("ecall", 32'h00000073, 0, PL_BRANCH, 0, 0, 0, 0, SYS_ECALL, CAP_NONE, 0));
  rows.push_back(dec_row("ebreak", 32'h00100073, 0, PL_BRANCH, 0, 0, 0, 0, SYS_EBRK, CAP_NONE, 0));
  rows.push_back(dec_row("mret", 32'h30200073, 0, PL_BRANCH, 0, 0, 0, 0, SYS_MRET, CAP_NONE, 0));
  rows.push_back(dec_row("dret", 32'h7b200073, 0, PL_BRANCH, 0, 0, 0, 0, SYS_DRET, CAP_NONE, 0));
  rows.push_back(dec_row("wfi", 32'h10500073, 0, PL_BRANCH, 0, 0, 0, 0, SYS_WFI, CAP_NONE, 0));
  rows.push_back(dec_row("fence_i", 32'h0000100f, 0, PL_BRANCH, 0, 0, 0, 0, SYS_FENCEI,
                         CAP_NONE, 0));
  rows.push_back(dec_row("csrrw", 32'h340110f3, 0, PL_MULT, 2, 0, 1, 4'b1011, SYS_CSRW,
                         CAP_NONE, 0));
  rows.push_back(dec_row("csrrs_x0", 32'h340020f3, 0, PL_MULT, 0, 0, 1, 4'b1011, SYS_NONE,
                         CAP_NONE, 0));
  // capability mode
  rows.push_back(dec_row("clc", 32'h0000b183, 1, PL_LS, 1, 0, 3, 4'b1010, SYS_NONE, CAP_CLC, 0));
  rows.push_back(dec_row("csc", 32'h0020b023, 1, PL_LS, 1, 2, 0, 4'b1100, SYS_NONE, CAP_CSC, 0));
  rows.push_back(dec_row("auipcc", 32'h00000297, 1, PL_ALU, 0, 0, 5, 4'b0010, SYS_NONE,
                         CAP_AUIPCC, 0));
  rows.push_back(dec_row("cjalr", 32'h000100e7, 1, PL_JALR, 2, 0, 1, 4'b1010, SYS_CJALR,
                         CAP_NONE, 0));
  rows.push_back(dec_row("rd_x17", 32'h002088b3, 1, PL_ALU, 0, 0, 0, 4'b0000, SYS_NONE,
                         CAP_NONE, 1));
  rows.push_back(dec_row("clc_nopm", 32'h0000b183, 0, PL_LS, 1, 0, 3, 4'b1010, SYS_NONE,
                         CAP_NONE, 1));
  // fetch bounds, nop in pmode
  b = ($random(seed) & 32'h3fff_fffc) | 32'h0000_1000;
  p = b + ($random(seed) & 32'h0000_fffc);
  r = dec_row("below_base", 32'h00000013, 1, PL_ALU, 0, 0, 0, 4'b1010, SYS_NONE, CAP_NONE, 0);
  r.base = b;
  r.pc = b - 4;
  r.exp_bvio = 1;
  rows.push_back(r);
  r.name = "below_base_dbg";
  r.dbg = 1;
  r.perms = 12'hffd;
  r.exp_bvio = 0;   // debug mode masks both checks
  rows.push_back(r);
  r.name = "hdrm2_full";
  r.dbg = 0;
  r.perms = 12'hfff;
  r.pc = p;
  r.top = {1'b0, p + 32'd2};
  r.exp_bvio = 1;
  rows.push_back(r);
  r.name = "hdrm2_comp";
  r.comp = 1;
  r.exp_bvio = 0;
  rows.push_back(r);
  r = dec_row("full_space", 32'h00000013, 1, PL_ALU, 0, 0, 0, 4'b1010, SYS_NONE, CAP_NONE, 0);
  r.pc = 32'hffff_fffe;
  rows.push_back(r);
  r = dec_row("no_ex", 32'h00000013, 1, PL_ALU, 0, 0, 0, 4'b1010, SYS_NONE, CAP_NONE, 0);
  r.perms = 12'hffd;
  r.exp_pvio = 1;
  rows.push_back(r);
  r = dec_row("mret_no_sr", 32'h30200073, 1, PL_BRANCH, 0, 0, 0, 0, SYS_MRET, CAP_NONE, 0);
  r.perms = 12'hbff;
  r.exp_pvio = 1;
  rows.push_back(r);
  r = dec_row("fetch_err", 32'h00000013, 0, PL_ALU, 0, 0, 0, 4'b1010, SYS_NONE, CAP_NONE, 0);
  r.ferr = 1;
  r.exp_ferr = 1;
  rows.push_back(r);
endtask

`endif

/* test/tb_ir_decoder.sv */
// self-checking testbench for ir_decoder_top with RV32M_EN at its default
// one row per cycle; each result is checked on the falling edge after capture
`default_nettype none
`include "ir_defs.svh"

module tb_ir_decoder import isa_pkg::*; import cap_pkg::*; ();

  typedef struct {
    string                 name;
    logic [`XLEN-1:0]      insn, pc, base;
    logic                  comp, ferr, pm, dbg, pvalid;
    logic [`PCC_TOP_W-1:0] top;
    logic [`PERM_W-1:0]    perms;
    logic [`OTYPE_W-1:0]   otype;
    pl_type_e              exp_pl;
    logic [4:0]            exp_rs1, exp_rs2, exp_rd;
    logic [3:0]            exp_en;   // ren_a, ren_b, we, is_csr
    sys_op_e               exp_sys;
    cap_op_e               exp_cap;
    logic                  exp_ill, exp_bvio, exp_pvio, exp_ferr, chk_tgt;
    logic [`XLEN-1:0]      exp_btarget, exp_pc_nxt;
  } row_t;

  logic clk_i, reset_i, valid_i, is_comp_i, fetch_err_i, cheri_pmode_i, debug_mode_i;
  logic [`XLEN-1:0] insn_i, pc_i, pcc_base_i;
  logic [`PCC_TOP_W-1:0] pcc_top_i;
  logic [`PERM_W-1:0] pcc_perms_i;
  logic pcc_valid_i;
  logic [`OTYPE_W-1:0] pcc_otype_i;
  logic valid_o, rf_ren_a_o, rf_ren_b_o, rf_we_o, is_csr_o;
  pl_type_e pl_type_o;
  sys_op_e sys_op_o;
  cap_op_e cap_op_o;
  logic [4:0] rs1_o, rs2_o, rd_o;
  logic [`XLEN-1:0] btarget_o, pc_nxt_o;
  logic illegal_insn_o, bound_vio_o, perm_vio_o, fetch_err_o, any_err_o;

  row_t rows[$];
  integer seed = 2601;
  integer errors = 0;
  integer cycles = 0;
  integer limit = 0;

  ir_decoder_top u_dut (.*);

  function automatic row_t dec_row(string n, logic [31:0] insn, logic pm, pl_type_e pl,
                                   logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd,
                                   logic [3:0] en, sys_op_e sys, cap_op_e cap, logic ill);
    row_t r;
    r.name = n;
    r.insn = insn;
    r.pc = 32'h0000_1000;
    r.base = '0;
    r.top = 33'h1_0000_0000;   // whole address space
    r.perms = 12'hfff;
    r.pvalid = 1;
    r.otype = '0;
    r.comp = 0;
    r.ferr = 0;
    r.pm = pm;
    r.dbg = 0;
    r.exp_pl = pl;
    r.exp_rs1 = rs1;
    r.exp_rs2 = rs2;
    r.exp_rd = rd;
    r.exp_en = en;
    r.exp_sys = sys;
    r.exp_cap = cap;
    r.exp_ill = ill;
    r.exp_bvio = 0;
    r.exp_pvio = 0;
    r.exp_ferr = 0;
    r.chk_tgt = 0;
    r.exp_btarget = '0;
    r.exp_pc_nxt = 32'h0000_1004;
    return r;
  endfunction

  `include "tb_vectors.svh"

  task automatic compare(string test, string field, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s expected %0h actual %0h", test, field, exp, act);
    end
  endtask

  task automatic drive_row(row_t r);
    valid_i = 1;
    insn_i = r.insn;
    pc_i = r.pc;
    is_comp_i = r.comp;
    fetch_err_i = r.ferr;
    cheri_pmode_i = r.pm;
    debug_mode_i = r.dbg;
    pcc_base_i = r.base;
    pcc_top_i = r.top;
    pcc_perms_i = r.perms;
    pcc_valid_i = r.pvalid;
    pcc_otype_i = r.otype;
  endtask

  task automatic check_row(row_t r);
    compare(r.name, "valid", 32'd1, 32'(valid_o));
    compare(r.name, "pl_type", 32'(r.exp_pl), 32'(pl_type_o));
    compare(r.name, "rs1", 32'(r.exp_rs1), 32'(rs1_o));
    compare(r.name, "rs2", 32'(r.exp_rs2), 32'(rs2_o));
    compare(r.name, "rd", 32'(r.exp_rd), 32'(rd_o));
    compare(r.name, "enables", 32'(r.exp_en),
            32'({rf_ren_a_o, rf_ren_b_o, rf_we_o, is_csr_o}));
    compare(r.name, "sys_op", 32'(r.exp_sys), 32'(sys_op_o));
    compare(r.name, "cap_op", 32'(r.exp_cap), 32'(cap_op_o));
    compare(r.name, "illegal", 32'(r.exp_ill), 32'(illegal_insn_o));
    compare(r.name, "bound_vio", 32'(r.exp_bvio), 32'(bound_vio_o));
    compare(r.name, "perm_vio", 32'(r.exp_pvio), 32'(perm_vio_o));
    compare(r.name, "fetch_err", 32'(r.exp_ferr), 32'(fetch_err_o));
    compare(r.name, "any_err", 32'(r.exp_ill | r.exp_bvio | r.exp_pvio | r.exp_ferr),
            32'(any_err_o));
    if (r.chk_tgt) begin
      compare(r.name, "btarget", r.exp_btarget, btarget_o);
      compare(r.name, "pc_nxt", r.exp_pc_nxt, pc_nxt_o);
    end
  endtask

  initial begin
    clk_i = 0;
    forever #2 clk_i = ~clk_i;
  end

  // run limit from the row count
  initial begin
    wait (limit > 0);
    while (cycles <= limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles before the table completed", cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset_i = 1;
    drive_row(dec_row("idle", 32'h00000013, 0, PL_ALU, 0, 0, 0, 0, SYS_NONE, CAP_NONE, 0));
    valid_i = 0;
    load_vectors();
    limit = rows.size() * 4 + 20;
    repeat (2) @(negedge clk_i);
    reset_i = 0;
    compare("reset", "valid", 32'd0, 32'(valid_o));
    compare("reset", "sys_op", 32'(SYS_NONE), 32'(sys_op_o));
    compare("reset", "cap_op", 32'(CAP_NONE), 32'(cap_op_o));
    foreach (rows[i]) begin
      @(negedge clk_i);
      if (i > 0) check_row(rows[i-1]);
      drive_row(rows[i]);
    end
    @(negedge clk_i);
    check_row(rows[rows.size()-1]);
    valid_i = 0;
    @(negedge clk_i);
    compare("idle", "valid", 32'd0, 32'(valid_o));
    $display("errors: %0d over %0d rows", errors, rows.size());
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/ir_decoder_top.sv */
// registered decode stage, result one cycle after valid_i
// no back-pressure, consumer must take each valid_o pulse
`default_nettype none
`include "ir_defs.svh"

module ir_decoder_top import isa_pkg::*; import cap_pkg::*; #(
  parameter bit RV32M_EN = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic [`XLEN-1:0]       insn_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic                   is_comp_i,
  input  logic                   fetch_err_i,
  input  logic                   cheri_pmode_i,
  input  logic                   debug_mode_i,
  input  logic [`XLEN-1:0]       pcc_base_i,
  input  logic [`PCC_TOP_W-1:0]  pcc_top_i,
  input  logic [`PERM_W-1:0]     pcc_perms_i,
  input  logic                   pcc_valid_i,
  input  logic [`OTYPE_W-1:0]    pcc_otype_i,
  output logic                   valid_o,
  output pl_type_e               pl_type_o,
  output logic [`REG_ADDR_W-1:0] rs1_o,
  output logic [`REG_ADDR_W-1:0] rs2_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic                   rf_we_o,
  output logic                   is_csr_o,
  output sys_op_e                sys_op_o,
  output cap_op_e                cap_op_o,
  output logic [`XLEN-1:0]       btarget_o,
  output logic [`XLEN-1:0]       pc_nxt_o,
  output logic                   illegal_insn_o,
  output logic                   bound_vio_o,
  output logic                   perm_vio_o,
  output logic                   fetch_err_o,
  output logic                   any_err_o
);

  pl_type_e               dec_pl_type;
  logic [`REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
  logic                   dec_ren_a, dec_ren_b, dec_we, dec_is_csr;
  sys_op_e                dec_sys_op;
  cap_op_e                dec_cap_op;
  logic                   dec_is_mret, dec_illegal;
  logic                   chk_bound_vio, chk_perm_vio;
  logic [`XLEN-1:0]       tgt_btarget, tgt_pc_nxt;

  opcode_decoder #(
    .RV32M_EN (RV32M_EN)
  ) u_opcode_decoder (
    .insn_i        (insn_i),
    .cheri_pmode_i (cheri_pmode_i),
    .pl_type_o     (dec_pl_type),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .rf_ren_a_o    (dec_ren_a),
    .rf_ren_b_o    (dec_ren_b),
    .rf_we_o       (dec_we),
    .is_csr_o      (dec_is_csr),
    .sys_op_o      (dec_sys_op),
    .cap_op_o      (dec_cap_op),
    .is_mret_o     (dec_is_mret),
    .illegal_o     (dec_illegal)
  );

  fetch_bounds_check u_fetch_bounds_check (
    .pc_i          (pc_i),
    .is_comp_i     (is_comp_i),
    .cheri_pmode_i (cheri_pmode_i),
    .debug_mode_i  (debug_mode_i),
    .is_mret_i     (dec_is_mret),
    .pcc_base_i    (pcc_base_i),
    .pcc_top_i     (pcc_top_i),
    .pcc_perms_i   (pcc_perms_i),
    .pcc_valid_i   (pcc_valid_i),
    .pcc_otype_i   (pcc_otype_i),
    .bound_vio_o   (chk_bound_vio),
    .perm_vio_o    (chk_perm_vio)
  );

  branch_target_calc u_branch_target_calc (
    .insn_i    (insn_i),
    .pc_i      (pc_i),
    .is_comp_i (is_comp_i),
    .btarget_o (tgt_btarget),
    .pc_nxt_o  (tgt_pc_nxt)
  );

  dec_output_reg u_dec_output_reg (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .fetch_err_i    (fetch_err_i),
    .pl_type_i      (dec_pl_type),
    .rs1_i          (dec_rs1),
    .rs2_i          (dec_rs2),
    .rd_i           (dec_rd),
    .rf_ren_a_i     (dec_ren_a),
    .rf_ren_b_i     (dec_ren_b),
    .rf_we_i        (dec_we),
    .is_csr_i       (dec_is_csr),
    .sys_op_i       (dec_sys_op),
    .cap_op_i       (dec_cap_op),
    .illegal_i      (dec_illegal),
    .bound_vio_i    (chk_bound_vio),
    .perm_vio_i     (chk_perm_vio),
    .btarget_i      (tgt_btarget),
    .pc_nxt_i       (tgt_pc_nxt),
    .valid_o        (valid_o),
    .pl_type_o      (pl_type_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .rd_o           (rd_o),
    .rf_ren_a_o     (rf_ren_a_o),
    .rf_ren_b_o     (rf_ren_b_o),
    .rf_we_o        (rf_we_o),
    .is_csr_o       (is_csr_o),
    .sys_op_o       (sys_op_o),
    .cap_op_o       (cap_op_o),
    .btarget_o      (btarget_o),
    .pc_nxt_o       (pc_nxt_o),
    .illegal_insn_o (illegal_insn_o),
    .bound_vio_o    (bound_vio_o),
    .perm_vio_o     (perm_vio_o),
    .fetch_err_o    (fetch_err_o),
    .any_err_o      (any_err_o)
  );

endmodule

`default_nettype wire

/* source/dec_output_reg.sv */
// one-cycle output stage; loads only when valid_i is high, holds otherwise
`default_nettype none
`include "ir_defs.svh"

module dec_output_reg import isa_pkg::*; import cap_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   valid_i,
  input  logic                   fetch_err_i,
  input  pl_type_e               pl_type_i,
  input  logic [`REG_ADDR_W-1:0] rs1_i,
  input  logic [`REG_ADDR_W-1:0] rs2_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  input  logic                   rf_ren_a_i,
  input  logic                   rf_ren_b_i,
  input  logic                   rf_we_i,
  input  logic                   is_csr_i,
  input  sys_op_e                sys_op_i,
  input  cap_op_e                cap_op_i,
  input  logic                   illegal_i,
  input  logic                   bound_vio_i,
  input  logic                   perm_vio_i,
  input  logic [`XLEN-1:0]       btarget_i,
  input  logic [`XLEN-1:0]       pc_nxt_i,
  output logic                   valid_o,
  output pl_type_e               pl_type_o,
  output logic [`REG_ADDR_W-1:0] rs1_o,
  output logic [`REG_ADDR_W-1:0] rs2_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic                   rf_we_o,
  output logic                   is_csr_o,
  output sys_op_e                sys_op_o,
  output cap_op_e                cap_op_o,
  output logic [`XLEN-1:0]       btarget_o,
  output logic [`XLEN-1:0]       pc_nxt_o,
  output logic                   illegal_insn_o,
  output logic                   bound_vio_o,
  output logic                   perm_vio_o,
  output logic                   fetch_err_o,
  output logic                   any_err_o
);

  //////////////////////////////////////////////////////////////////////
  // control and error flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o        <= 1'b0;
      rf_ren_a_o     <= 1'b0;
      rf_ren_b_o     <= 1'b0;
      rf_we_o        <= 1'b0;
      is_csr_o       <= 1'b0;
      sys_op_o       <= SYS_NONE;
      cap_op_o       <= CAP_NONE;
      illegal_insn_o <= 1'b0;
      bound_vio_o    <= 1'b0;
      perm_vio_o     <= 1'b0;
      fetch_err_o    <= 1'b0;
      any_err_o      <= 1'b0;
    end else begin
      valid_o <= valid_i;   // single-cycle pulse per item
      if (valid_i) begin
        rf_ren_a_o     <= rf_ren_a_i;
        rf_ren_b_o     <= rf_ren_b_i;
        rf_we_o        <= rf_we_i;
        is_csr_o       <= is_csr_i;
        sys_op_o       <= sys_op_i;
        cap_op_o       <= cap_op_i;
        illegal_insn_o <= illegal_i;
        bound_vio_o    <= bound_vio_i;
        perm_vio_o     <= perm_vio_i;
        fetch_err_o    <= fetch_err_i;
        any_err_o      <= illegal_i | bound_vio_i | perm_vio_i | fetch_err_i;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      pl_type_o <= pl_type_i;
      rs1_o     <= rs1_i;
      rs2_o     <= rs2_i;
      rd_o      <= rd_i;
      btarget_o <= btarget_i;
      pc_nxt_o  <= pc_nxt_i;
    end
  end

endmodule

`default_nettype wire

/* source/branch_target_calc.sv */
// jal/branch target and fall-through pc; no alignment check here
`default_nettype none
`include "ir_defs.svh"

module branch_target_calc import isa_pkg::*; (
  input  logic [`XLEN-1:0] insn_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic             is_comp_i,
  output logic [`XLEN-1:0] btarget_o,
  output logic [`XLEN-1:0] pc_nxt_o
);

  localparam logic [`XLEN-1:0] STEP_C = 2;   // compressed
  localparam logic [`XLEN-1:0] STEP_N = 4;

  logic [`XLEN-1:0] imm_j, imm_b;
  logic             is_jal;

  assign is_jal = (insn_i[6:0] == OPCODE_JAL);

  assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_b = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

  // non-branch opcodes still get a b-type sum, consumer ignores it
  assign btarget_o = pc_i + (is_jal ? imm_j : imm_b);
  assign pc_nxt_o  = pc_i + (is_comp_i ? STEP_C : STEP_N);

endmodule

`default_nettype wire

/* source/fetch_bounds_check.sv */
// pcc check of the fetched pc; silent outside capability mode and in debug
`default_nettype none
`include "ir_defs.svh"

module fetch_bounds_check import cap_pkg::*; (
  input  logic [`XLEN-1:0]      pc_i,
  input  logic                  is_comp_i,
  input  logic                  cheri_pmode_i,
  input  logic                  debug_mode_i,
  input  logic                  is_mret_i,
  input  logic [`XLEN-1:0]      pcc_base_i,
  input  logic [`PCC_TOP_W-1:0] pcc_top_i,
  input  logic [`PERM_W-1:0]    pcc_perms_i,
  input  logic                  pcc_valid_i,
  input  logic [`OTYPE_W-1:0]   pcc_otype_i,
  output logic                  bound_vio_o,
  output logic                  perm_vio_o
);

  logic [`PCC_TOP_W:0] hdrm;   // extra msb flags pc above top
  logic                hdrm_ge2, hdrm_ge4, hdrm_ok, base_ok;
  logic                allow_all, chk_en;

  assign chk_en = cheri_pmode_i & ~debug_mode_i;

  // full 4GiB pcc, lets a 32-bit fetch at 0xffff_fffe through
  assign allow_all = (pcc_base_i == '0) & pcc_top_i[`PCC_TOP_W-1];

  assign hdrm     = {1'b0, pcc_top_i} - {{(`PCC_TOP_W + 1 - `XLEN){1'b0}}, pc_i};
  assign hdrm_ge4 = (|hdrm[`PCC_TOP_W-1:2]) & ~hdrm[`PCC_TOP_W];
  assign hdrm_ge2 = (|hdrm[`PCC_TOP_W-1:1]) & ~hdrm[`PCC_TOP_W];
  assign hdrm_ok  = allow_all | (is_comp_i ? hdrm_ge2 : hdrm_ge4);
  assign base_ok  = (pc_i >= pcc_base_i);

  assign bound_vio_o = chk_en & (~base_ok | ~hdrm_ok);

  assign perm_vio_o = chk_en & (~pcc_perms_i[PERM_EX] | ~pcc_valid_i | (pcc_otype_i != '0) |
                                (is_mret_i & ~pcc_perms_i[PERM_SR]));

endmodule

`default_nettype wire

/* source/opcode_decoder.sv */
// combinational RV32I(+M) decode; B-extension encodings are illegal
// in capability mode only x0..x15 may be referenced
`default_nettype none
`include "ir_defs.svh"

module opcode_decoder import isa_pkg::*; import cap_pkg::*; #(
  parameter bit RV32M_EN = 1'b1
) (
  input  logic [`XLEN-1:0]       insn_i,
  input  logic                   cheri_pmode_i,
  output pl_type_e               pl_type_o,
  output logic [`REG_ADDR_W-1:0] rs1_o,
  output logic [`REG_ADDR_W-1:0] rs2_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic                   rf_we_o,
  output logic                   is_csr_o,
  output sys_op_e                sys_op_o,
  output cap_op_e                cap_op_o,
  output logic                   is_mret_o,
  output logic                   illegal_o
);

  localparam logic [`REG_ADDR_W-1:0] CAP_IDX_BIT = 1 << `CAP_REG_LIMIT_BIT;

  opcode_e                 opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`REG_ADDR_W-1:0]  rs1_raw, rs2_raw, rd_raw;
  logic [`REG_ADDR_W-1:0]  addr_mask;
  logic                    ren_a, ren_b, we;
  logic                    illegal_insn, illegal_reg;

  assign opcode  = opcode_e'(insn_i[6:0]);
  assign funct3  = insn_i[14:12];
  assign funct7  = insn_i[31:25];
  assign rs1_raw = insn_i[19:15];
  assign rs2_raw = insn_i[24:20];
  assign rd_raw  = insn_i[11:7];

  //////////////////////////////////////////////////////////////////////
  // major opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pl_type_o    = PL_ALU;
    ren_a        = 1'b0;
    ren_b        = 1'b0;
    we           = 1'b0;
    illegal_insn = 1'b0;
    is_csr_o     = 1'b0;
    is_mret_o    = 1'b0;
    sys_op_o     = SYS_NONE;
    cap_op_o     = CAP_NONE;

    case (opcode)
      OPCODE_JAL: begin
        pl_type_o = PL_JAL;
        we        = 1'b1;
      end
      OPCODE_JALR: begin
        pl_type_o    = PL_JALR;
        ren_a        = 1'b1;
        we           = 1'b1;
        illegal_insn = (funct3 != 3'b000);
        if (cheri_pmode_i) sys_op_o = SYS_CJALR;   // cap jump needs the controller
      end
      OPCODE_BRANCH: begin
        pl_type_o    = PL_BRANCH;
        ren_a        = 1'b1;
        ren_b        = 1'b1;
        illegal_insn = (funct3[2:1] == 2'b01);
      end
      OPCODE_LOAD: begin
        pl_type_o    = PL_LS;
        ren_a        = 1'b1;
        we           = 1'b1;
        // width 3 is a capability load, only legal in pmode
        illegal_insn = (funct3[2:1] == 2'b11) || (~cheri_pmode_i && funct3 == 3'b011);
        if (cheri_pmode_i && funct3 == 3'b011) cap_op_o = CAP_CLC;
      end
      OPCODE_STORE: begin
        pl_type_o    = PL_LS;
        ren_a        = 1'b1;
        ren_b        = 1'b1;
        illegal_insn = funct3[2] | (~cheri_pmode_i && funct3[1:0] == 2'b11);
        if (cheri_pmode_i && funct3 == 3'b011) cap_op_o = CAP_CSC;
      end
      OPCODE_LUI: begin
        we = 1'b1;
      end
      OPCODE_AUIPC: begin
        we = 1'b1;
        if (cheri_pmode_i) cap_op_o = CAP_AUIPCC;
      end
      OPCODE_OP_IMM: begin
        ren_a = 1'b1;
        we    = 1'b1;
        if (funct3 == 3'b001) begin
          illegal_insn = (funct7 != 7'h00);                    // slli only
        end else if (funct3 == 3'b101) begin
          illegal_insn = (funct7 != 7'h00) && (funct7 != 7'h20); // srli, srai
        end
      end
      OPCODE_OP: begin
        ren_a = 1'b1;
        ren_b = 1'b1;
        we    = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}, {7'h20, 3'b000}, {7'h00, 3'b001}, {7'h00, 3'b010},
          {7'h00, 3'b011}, {7'h00, 3'b100}, {7'h00, 3'b101}, {7'h20, 3'b101},
          {7'h00, 3'b110}, {7'h00, 3'b111}: begin
            pl_type_o = PL_ALU;
          end
          {7'h01, 3'b000}, {7'h01, 3'b001}, {7'h01, 3'b010}, {7'h01, 3'b011},
          {7'h01, 3'b100}, {7'h01, 3'b101}, {7'h01, 3'b110}, {7'h01, 3'b111}: begin
            pl_type_o    = PL_MULT;   // mul/div family
            illegal_insn = ~RV32M_EN;
          end
          default: illegal_insn = 1'b1;
        endcase
      end
      OPCODE_MISC_MEM: begin
        pl_type_o = PL_BRANCH;
        case (funct3)
          3'b000:  ;                        // fence is a nop here
          3'b001:  sys_op_o = SYS_FENCEI;   // flush via jump to next pc
          default: illegal_insn = 1'b1;
        endcase
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          pl_type_o = PL_BRANCH;
          case (insn_i[31:20])
            `SYS_F12_ECALL:  sys_op_o = SYS_ECALL;
            `SYS_F12_EBREAK: sys_op_o = SYS_EBRK;
            `SYS_F12_DRET:   sys_op_o = SYS_DRET;
            `SYS_F12_WFI:    sys_op_o = SYS_WFI;
            `SYS_F12_MRET: begin
              sys_op_o  = SYS_MRET;
              is_mret_o = 1'b1;
            end
            default: illegal_insn = 1'b1;
          endcase
          if (rs1_raw != '0 || rd_raw != '0) illegal_insn = 1'b1;
        end else begin
          // csr access; set/clear with rs1 == x0 only reads
          is_csr_o     = 1'b1;
          pl_type_o    = PL_MULT;
          ren_a        = ~funct3[2];
          we           = 1'b1;
          sys_op_o     = (funct3[1] && rs1_raw == '0) ? SYS_NONE : SYS_CSRW;
          illegal_insn = (funct3[1:0] == 2'b00);
        end
      end
      default: illegal_insn = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // capability-mode register limit
  //////////////////////////////////////////////////////////////////////

  assign illegal_reg = cheri_pmode_i & ((ren_a & rs1_raw[`CAP_REG_LIMIT_BIT]) |
                                        (ren_b & rs2_raw[`CAP_REG_LIMIT_BIT]) |
                                        (we    & rd_raw[`CAP_REG_LIMIT_BIT]));
  assign addr_mask   = cheri_pmode_i ? ~CAP_IDX_BIT : '1;

  assign rf_ren_a_o = ren_a & ~illegal_reg;
  assign rf_ren_b_o = ren_b & ~illegal_reg;
  assign rf_we_o    = we & ~illegal_reg;

  // unused index reads as zero
  assign rs1_o = rf_ren_a_o ? (rs1_raw & addr_mask) : '0;
  assign rs2_o = rf_ren_b_o ? (rs2_raw & addr_mask) : '0;
  assign rd_o  = rf_we_o    ? (rd_raw & addr_mask)  : '0;

  assign illegal_o = illegal_insn | illegal_reg;

endmodule

`default_nettype wire

/* source/cap_pkg.sv */
// CHERIoT capability-mode types; only the ops decoded at this stage
`default_nettype none

package cap_pkg;

  typedef enum logic [1:0] {
    CAP_NONE   = 2'd0,
    CAP_AUIPCC = 2'd1,
    CAP_CLC    = 2'd2,
    CAP_CSC    = 2'd3
  } cap_op_e;

  // bit positions inside the 12-bit permission vector
  typedef enum logic [3:0] {
    PERM_GL = 4'd0,
    PERM_EX = 4'd1,   // execute
    PERM_LD = 4'd2,
    PERM_SD = 4'd3,
    PERM_MC = 4'd4,
    PERM_SL = 4'd5,
    PERM_LG = 4'd6,
    PERM_LM = 4'd7,
    PERM_SE = 4'd8,
    PERM_US = 4'd9,
    PERM_SR = 4'd10   // system registers
  } perm_idx_e;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
// RV32I base encodings and the decode-stage classes derived from them
`default_nettype none

package isa_pkg;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  // which execution pipe takes the instruction
  typedef enum logic [2:0] {
    PL_ALU    = 3'd0,
    PL_MULT   = 3'd1,   // also csr accesses
    PL_LS     = 3'd2,
    PL_BRANCH = 3'd3,
    PL_JAL    = 3'd4,
    PL_JALR   = 3'd5
  } pl_type_e;

  // anything but SYS_NONE goes down the controller special path
  typedef enum logic [3:0] {
    SYS_NONE   = 4'd0,
    SYS_CSRW   = 4'd1,
    SYS_MRET   = 4'd2,
    SYS_DRET   = 4'd3,
    SYS_WFI    = 4'd4,
    SYS_EBRK   = 4'd5,
    SYS_ECALL  = 4'd6,
    SYS_CJALR  = 4'd7,
    SYS_FENCEI = 4'd8
  } sys_op_e;

endpackage

`default_nettype wire

/* source/ir_defs.svh */
// shared widths and fixed encodings for the decode stage
// RV32 only; the pcc top carries one extra bit for the full-space case
`ifndef IR_DEFS_SVH
`define IR_DEFS_SVH

// datapath
`define XLEN              32
`define REG_ADDR_W        5
`define CAP_REG_LIMIT_BIT 4   // only x0..x15 exist in capability mode

// pcc fields
`define PCC_TOP_W         33
`define PERM_W            12
`define OTYPE_W           3

// SYSTEM funct12 codes (funct3 == 0)
`define SYS_F12_ECALL     12'h000
`define SYS_F12_EBREAK    12'h001
`define SYS_F12_MRET      12'h302
`define SYS_F12_DRET      12'h7b2
`define SYS_F12_WFI       12'h105

`endif
